// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_mycpu -f vlog.f -o tb_mycpu

./obj_dir/tb_mycpu

// ==== source/core_pkg.sv ====
// type widths follow core_settings.svh; every type here is an unsigned plain vector
`include "core_settings.svh"

package core_pkg;

    // data word, also used for every address and pc value
    typedef logic [`WORD_W-1:0]     word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;    // gpr number

    // alu operation, codes are the ALU_* macros
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;

    typedef logic [3:0]             wen_t;         // byte enables of the trace port

endpackage

// ==== source/core_settings.svh ====
// widths and encodings for the 32-bit integer pipeline; only the listed opcodes are decoded
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define ALU_OP_W    4
`define RESET_PC    32'h0000_0000   // first fetch after reset

// opcode field, instr[31:26]
`define OP_SPECIAL  6'h00
`define OP_J        6'h02
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// function field of SPECIAL, instr[5:0]
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_SLT     4'd4
`define ALU_LUI     4'd5    // b shifted up by 16

`endif

// ==== source/decode_stage.sv ====
// unknown opcodes and function codes decode to no-ops; stalls only for a load directly ahead
`timescale 1ns/100ps
`include "core_settings.svh"

module decode_stage import core_pkg::*; (
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     if_valid,
    input  word_t    if_pc,
    input  word_t    if_instr,
    input  logic     redirect,
    wb_bus.sink      wb,
    id_ex_bus.source id_ex,
    output logic     load_stall
);
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs_num;
    reg_addr_t  rt_num;
    reg_addr_t  rd_num;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      imm;
    reg_addr_t  dst;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_wr;
    logic       mem_rd;
    logic       mem_wr;
    logic       is_beq;
    logic       is_bne;
    logic       is_j;
    logic       uses_rs;
    logic       uses_rt;

    assign opcode   = if_instr[31:26];
    assign rs_num   = if_instr[25:21];
    assign rt_num   = if_instr[20:16];
    assign rd_num   = if_instr[15:11];
    assign funct    = if_instr[5:0];
    assign imm_sext = {{16{if_instr[15]}}, if_instr[15:0]};
    assign imm_zext = {16'h0000, if_instr[15:0]};

    reg_file u_reg_file (
        .aclk   (aclk),
        .arst_n (arst_n),
        .rs_num (rs_num),
        .rt_num (rt_num),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb     (wb)
    );

    always_comb begin
        alu_op  = `ALU_ADD;
        use_imm = 1'b0;
        reg_wr  = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_j    = 1'b0;
        dst     = rt_num;   // i-type default
        imm     = imm_sext;
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                dst     = rd_num;
                uses_rt = 1'b1;
                reg_wr  = 1'b1;
                case (funct)
                    `FN_ADDU: alu_op = `ALU_ADD;
                    `FN_SUBU: alu_op = `ALU_SUB;
                    `FN_AND:  alu_op = `ALU_AND;
                    `FN_OR:   alu_op = `ALU_OR;
                    `FN_SLT:  alu_op = `ALU_SLT;
                    default:  reg_wr = 1'b0;    // sll nop and the rest
                endcase
            end
            `OP_ADDIU: begin
                use_imm = 1'b1;
                reg_wr  = 1'b1;
            end
            `OP_LUI: begin
                alu_op  = `ALU_LUI;
                use_imm = 1'b1;
                reg_wr  = 1'b1;
                imm     = imm_zext;
                uses_rs = 1'b0;
            end
            `OP_LW: begin
                use_imm = 1'b1;
                reg_wr  = 1'b1;
                mem_rd  = 1'b1;
            end
            `OP_SW: begin
                use_imm = 1'b1;
                mem_wr  = 1'b1;
                uses_rt = 1'b1;     // store data
            end
            `OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            `OP_BNE: begin
                is_bne  = 1'b1;
                uses_rt = 1'b1;
            end
            `OP_J: begin
                is_j    = 1'b1;
                imm     = {6'b000000, if_instr[25:0]};  // jump index
                uses_rs = 1'b0;
            end
            default: uses_rs = 1'b0;
        endcase
    end

    // load in EX feeding this instruction, its data is only ready in MEM
    assign load_stall = if_valid && id_ex.valid && id_ex.mem_rd && (id_ex.dst != '0) &&
                        ((uses_rs && id_ex.dst == rs_num) || (uses_rt && id_ex.dst == rt_num));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            id_ex.valid <= 1'b0;
        else
            id_ex.valid <= if_valid && !load_stall && !redirect;  // bubble on stall or flush
    end

    // ID/EX payload
    always_ff @(posedge aclk) begin
        id_ex.pc      <= if_pc;
        id_ex.rs_num  <= rs_num;
        id_ex.rt_num  <= rt_num;
        id_ex.rs_val  <= rs_val;
        id_ex.rt_val  <= rt_val;
        id_ex.imm     <= imm;
        id_ex.dst     <= dst;
        id_ex.alu_op  <= alu_op;
        id_ex.use_imm <= use_imm;
        id_ex.reg_wr  <= reg_wr;
        id_ex.mem_rd  <= mem_rd;
        id_ex.mem_wr  <= mem_wr;
        id_ex.is_beq  <= is_beq;
        id_ex.is_bne  <= is_bne;
        id_ex.is_j    <= is_j;
    end

endmodule

// ==== source/execute_stage.sv ====
// branches resolve here with no delay slot; a load in EX/MEM is never forwarded, decode stalls instead
`timescale 1ns/100ps
`include "core_settings.svh"

module execute_stage import core_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    id_ex_bus.sink    id_ex,
    ex_mem_bus.source ex_mem,
    wb_bus.sink       wb,
    output logic      redirect,
    output word_t     redirect_pc
);
    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_out;
    word_t pc_plus4;
    logic  taken;

    // operand bypass, the younger result wins
    always_comb begin
        op_a = id_ex.rs_val;
        if (ex_mem.valid && ex_mem.reg_wr && !ex_mem.mem_rd &&
            ex_mem.dst != '0 && ex_mem.dst == id_ex.rs_num)
            op_a = ex_mem.result;
        else if (wb.valid && wb.reg_wr && wb.dst != '0 && wb.dst == id_ex.rs_num)
            op_a = wb.data;

        op_b = id_ex.rt_val;
        if (ex_mem.valid && ex_mem.reg_wr && !ex_mem.mem_rd &&
            ex_mem.dst != '0 && ex_mem.dst == id_ex.rt_num)
            op_b = ex_mem.result;
        else if (wb.valid && wb.reg_wr && wb.dst != '0 && wb.dst == id_ex.rt_num)
            op_b = wb.data;
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            `ALU_ADD: alu_out = op_a + alu_b;
            `ALU_SUB: alu_out = op_a - alu_b;
            `ALU_AND: alu_out = op_a & alu_b;
            `ALU_OR:  alu_out = op_a | alu_b;
            `ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            `ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
            default:  alu_out = '0;
        endcase
    end

    assign pc_plus4 = id_ex.pc + 32'd4;
    assign taken    = id_ex.is_j ||
                      (id_ex.is_beq && op_a == op_b) ||
                      (id_ex.is_bne && op_a != op_b);

    assign redirect    = id_ex.valid && taken;
    assign redirect_pc = id_ex.is_j ? {pc_plus4[31:28], id_ex.imm[25:0], 2'b00}
                                    : pc_plus4 + {id_ex.imm[29:0], 2'b00};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.reg_wr <= 1'b0;
            ex_mem.mem_rd <= 1'b0;
            ex_mem.mem_wr <= 1'b0;
        end else begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.reg_wr <= id_ex.reg_wr;
            ex_mem.mem_rd <= id_ex.mem_rd;
            ex_mem.mem_wr <= id_ex.mem_wr;
        end
    end

    always_ff @(posedge aclk) begin
        ex_mem.pc         <= id_ex.pc;
        ex_mem.result     <= alu_out;
        ex_mem.store_data <= op_b;      // sw writes rt
        ex_mem.dst        <= id_ex.dst;
    end

endmodule

// ==== source/fetch_stage.sv ====
// inst_rdata must be valid in the same cycle as inst_addr; redirect takes priority over load_stall
`timescale 1ns/100ps
`include "core_settings.svh"

module fetch_stage import core_pkg::*; (
    input  logic  aclk,
    input  logic  arst_n,
    input  logic  load_stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  word_t inst_rdata,
    output word_t inst_addr,
    output logic  if_valid,
    output word_t if_pc,
    output word_t if_instr
);
    word_t pc;
    word_t next_pc;

    assign inst_addr = pc;

    always_comb begin
        if (redirect)
            next_pc = redirect_pc;
        else if (load_stall)
            next_pc = pc;           // refetch the same word
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            if_valid <= 1'b0;
        end else begin
            pc <= next_pc;
            if (redirect)
                if_valid <= 1'b0;   // wrong-path word
            else if (!load_stall)
                if_valid <= 1'b1;
        end
    end

    // IF/ID payload
    always_ff @(posedge aclk) begin
        if (!load_stall) begin
            if_pc    <= pc;
            if_instr <= inst_rdata;
        end
    end

endmodule

// ==== source/mem_wb_stage.sv ====
// single-cycle data memory: data_rdata must answer data_addr in the same cycle, word accesses only
`timescale 1ns/100ps

module mem_wb_stage import core_pkg::*; (
    input  logic     aclk,
    input  logic     arst_n,
    ex_mem_bus.sink  ex_mem,
    output word_t    data_addr,
    output word_t    data_wdata,
    output logic     data_we,
    input  word_t    data_rdata,
    wb_bus.source    wb
);
    word_t wb_data;

    assign data_addr  = ex_mem.result;
    assign data_wdata = ex_mem.store_data;
    assign data_we    = ex_mem.valid && ex_mem.mem_wr;    // bubbles never store

    assign wb_data = ex_mem.mem_rd ? data_rdata : ex_mem.result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb.valid  <= 1'b0;
            wb.reg_wr <= 1'b0;
        end else begin
            wb.valid  <= ex_mem.valid;
            wb.reg_wr <= ex_mem.reg_wr;
        end
    end

    // MEM/WB payload
    always_ff @(posedge aclk) begin
        wb.pc   <= ex_mem.pc;
        wb.dst  <= ex_mem.dst;
        wb.data <= wb_data;
    end

endmodule

// ==== source/mycpu_top.sv ====
// no handshake on either memory port; trace outputs show the WB stage, wen is all or nothing
`timescale 1ns/100ps

module mycpu_top import core_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    output word_t     inst_addr,
    input  word_t     inst_rdata,
    output word_t     data_addr,
    output word_t     data_wdata,
    output logic      data_we,
    input  word_t     data_rdata,
    output word_t     debug_wb_pc,
    output word_t     debug_wb_rf_wdata,
    output wen_t      debug_wb_rf_wen,
    output reg_addr_t debug_wb_rf_wnum
);
    logic  if_valid;
    word_t if_pc;
    word_t if_instr;
    logic  load_stall;
    logic  redirect;
    word_t redirect_pc;

    id_ex_bus  id_ex ();
    ex_mem_bus ex_mem ();
    wb_bus     wb ();

    // golden trace
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wdata = wb.data;
    assign debug_wb_rf_wnum  = wb.dst;
    assign debug_wb_rf_wen   = {4{wb.valid && wb.reg_wr && (wb.dst != '0)}};

    fetch_stage u_fetch_stage (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .load_stall  (load_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_rdata  (inst_rdata),
        .inst_addr   (inst_addr),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    decode_stage u_decode_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_instr   (if_instr),
        .redirect   (redirect),
        .wb         (wb.sink),
        .id_ex      (id_ex.source),
        .load_stall (load_stall)
    );

    execute_stage u_execute_stage (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .id_ex       (id_ex.sink),
        .ex_mem      (ex_mem.source),
        .wb          (wb.sink),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    mem_wb_stage u_mem_wb_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem.sink),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .wb         (wb.source)
    );

endmodule

// ==== source/pipe_if.sv ====
// pipeline register buses; the source side owns the register, fields are meaningless when valid is low
`timescale 1ns/100ps

interface id_ex_bus import core_pkg::*; ();
    logic      valid;
    word_t     pc;
    reg_addr_t rs_num;
    reg_addr_t rt_num;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;      // extended immediate, or the jump index for j
    reg_addr_t dst;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      reg_wr;
    logic      mem_rd;
    logic      mem_wr;
    logic      is_beq;
    logic      is_bne;
    logic      is_j;

    modport source (
        output valid, pc, rs_num, rt_num, rs_val, rt_val, imm, dst, alu_op,
               use_imm, reg_wr, mem_rd, mem_wr, is_beq, is_bne, is_j
    );
    modport sink (
        input  valid, pc, rs_num, rt_num, rs_val, rt_val, imm, dst, alu_op,
               use_imm, reg_wr, mem_rd, mem_wr, is_beq, is_bne, is_j
    );
endinterface

interface ex_mem_bus import core_pkg::*; ();
    logic      valid;
    word_t     pc;
    word_t     result;      // alu result, the address for lw and sw
    word_t     store_data;
    reg_addr_t dst;
    logic      reg_wr;
    logic      mem_rd;
    logic      mem_wr;

    modport source (output valid, pc, result, store_data, dst, reg_wr, mem_rd, mem_wr);
    modport sink   (input  valid, pc, result, store_data, dst, reg_wr, mem_rd, mem_wr);
endinterface

interface wb_bus import core_pkg::*; ();
    logic      valid;
    word_t     pc;
    reg_addr_t dst;
    logic      reg_wr;
    word_t     data;

    modport source (output valid, pc, dst, reg_wr, data);
    modport sink   (input  valid, pc, dst, reg_wr, data);
endinterface

// ==== source/reg_file.sv ====
// two read ports and one write port from wb; register zero reads zero, same-cycle writes bypass to reads
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    input  reg_addr_t rs_num,
    input  reg_addr_t rt_num,
    output word_t     rs_val,
    output word_t     rt_val,
    wb_bus.sink       wb
);
    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb.valid && wb.reg_wr && (wb.dst != '0);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.dst] <= wb.data;
        end
    end

    // read with write-through
    always_comb begin
        if (rs_num == '0)
            rs_val = '0;
        else if (wr_en && wb.dst == rs_num)
            rs_val = wb.data;
        else
            rs_val = regs[rs_num];

        if (rt_num == '0)
            rt_val = '0;
        else if (wr_en && wb.dst == rt_num)
            rt_val = wb.data;
        else
            rt_val = regs[rt_num];
    end

endmodule

// ==== tb/program_input.txt ====
# I word | D addr value | T pc wnum wdata | S addr data, all hex
# program starts at 0 and ends in a j-to-self loop
D 00000100 00ff00f0
D 00000104 0f0f0f0f
I 3c011234 # lui $1, 0x1234
I 24020100 # addiu $2, $0, 0x100
I 8c430000 # lw $3, 0($2)
I 8c440004 # lw $4, 4($2)
I 00642821 # addu $5, $3, $4 load-use
I 00833023 # subu $6, $4, $3
I 00643824 # and $7, $3, $4
I 00644025 # or $8, $3, $4
I 00c5482a # slt $9, $6, $5
I 0026502a # slt $10, $1, $6
I 240bffff # addiu $11, $0, -1
I 0160602a # slt $12, $11, $0
I 258d0005 # addiu $13, $12, 5
I 01ac7021 # addu $14, $13, $12
I 01cd7823 # subu $15, $14, $13
I 24000055 # addiu $0, $0, 0x55
I 000f8021 # addu $16, $0, $15
I 00220025 # or $0, $1, $2
I 00028825 # or $17, $0, $2
I ac410008 # sw $1, 8($2)
I 8c520008 # lw $18, 8($2)
I 26530001 # addiu $19, $18, 1 load-use
I ac53000c # sw $19, 12($2)
I 120f0002 # beq $16, $15, taken to 0x68
I 24140bad # flushed
I 24150bad # flushed
I 160f0003 # bne $16, $15, not taken
I 24160022 # addiu $22, $0, 0x22
I 0800001f # j 0x7c
I 24170bad # flushed
I 24180bad # flushed
I 26da0010 # addiu $26, $22, 0x10
I 08000020 # j 0x80 self loop
T 00000000 01 12340000
T 00000004 02 00000100
T 00000008 03 00ff00f0
T 0000000c 04 0f0f0f0f
T 00000010 05 100e0fff
T 00000014 06 0e100e1f
T 00000018 07 000f0000
T 0000001c 08 0fff0fff
T 00000020 09 00000001
T 00000024 0a 00000000
T 00000028 0b ffffffff
T 0000002c 0c 00000001
T 00000030 0d 00000006
T 00000034 0e 00000007
T 00000038 0f 00000001
T 00000040 10 00000001
T 00000048 11 00000100
T 00000050 12 12340000
T 00000054 13 12340001
T 0000006c 16 00000022
T 0000007c 1a 00000032
S 00000108 12340000
S 0000010c 12340001

// ==== tb/tb_mycpu.sv ====
// run from the project root so tb/program_input.txt is found; tags in that file are one character
`timescale 1ns/100ps

module tb_mycpu import core_pkg::*; ();

    logic      aclk;
    logic      arst_n;
    word_t     inst_addr;
    word_t     inst_rdata;
    word_t     data_addr;
    word_t     data_wdata;
    logic      data_we;
    word_t     data_rdata;
    word_t     debug_wb_pc;
    word_t     debug_wb_rf_wdata;
    wen_t      debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;

    word_t     imem [word_t];     // keyed by byte address
    word_t     dmem [word_t];
    word_t     exp_pc_q [$];
    reg_addr_t exp_wnum_q [$];
    word_t     exp_wdata_q [$];
    word_t     exp_st_addr_q [$];
    word_t     exp_st_data_q [$];
    int        n_words = 0;
    int        cycle_count = 0;
    int        cycle_limit = 0;

    mycpu_top uut (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_we           (data_we),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    task automatic end_in_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
            end_in_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
            end_in_failure();
        end
    endtask

    task automatic check_wen(input string name, input wen_t got, input wen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
            end_in_failure();
        end
    endtask

    // one tagged record per token group, '#' skips to end of line
    task automatic load_program();
        int              fd;
        int              code;
        logic [7:0]      tag;
        logic [8*200-1:0] rest;
        word_t           a;
        word_t           b;
        word_t           c;
        word_t           load_addr;
        load_addr = '0;
        fd = $fopen("tb/program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/program_input.txt");
            end_in_failure();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                break;
            case (tag)
                "#": code = $fgets(rest, fd);
                "I": begin
                    code = $fscanf(fd, "%h", a);
                    imem[load_addr] = a;
                    load_addr = load_addr + 32'd4;
                    n_words++;
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    dmem[a] = b;
                end
                "T": begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    exp_pc_q.push_back(a);
                    exp_wnum_q.push_back(b[4:0]);
                    exp_wdata_q.push_back(c);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    exp_st_addr_q.push_back(a);
                    exp_st_data_q.push_back(b);
                end
                default: begin
                    $display("unknown record tag in tb/program_input.txt");
                    end_in_failure();
                end
            endcase
        end
        $fclose(fd);
        cycle_limit = 4 * n_words + 40;
    endtask

    function automatic word_t fetch_word(input word_t addr);
        if (imem.exists(addr))
            return imem[addr];
        return '0;  // outside the program reads as nop
    endfunction

    function automatic word_t read_data(input word_t addr);
        if (dmem.exists(addr))
            return dmem[addr];
        return ~addr;
    endfunction

    // memory models answer on the falling edge, stores land first
    always @(negedge aclk) begin
        if (arst_n && data_we) begin
            if (exp_st_addr_q.size() == 0) begin
                $display("store to %h seen with no store left to expect", data_addr);
                end_in_failure();
            end
            check_word("data_addr", data_addr, exp_st_addr_q.pop_front());
            check_word("data_wdata", data_wdata, exp_st_data_q.pop_front());
            dmem[data_addr] = data_wdata;
        end
        inst_rdata = fetch_word(inst_addr);
        data_rdata = read_data(data_addr);
    end

    // golden trace compare in program order
    always @(negedge aclk) begin
        if (arst_n && debug_wb_rf_wen != '0) begin
            if (exp_pc_q.size() == 0) begin
                $display("register write at pc %h seen after the last expected one",
                         debug_wb_pc);
                end_in_failure();
            end
            check_wen("debug_wb_rf_wen", debug_wb_rf_wen, 4'hf);
            check_word("debug_wb_pc", debug_wb_pc, exp_pc_q.pop_front());
            check_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wnum_q.pop_front());
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata_q.pop_front());
        end
    end

    initial begin
        arst_n     = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        load_program();
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;

        while ((exp_pc_q.size() != 0 || exp_st_addr_q.size() != 0) &&
               cycle_count < cycle_limit)
            @(posedge aclk);

        if (exp_pc_q.size() != 0 || exp_st_addr_q.size() != 0) begin
            $display("timeout after %0d cycles, %0d trace and %0d store entries never seen",
                     cycle_count, exp_pc_q.size(), exp_st_addr_q.size());
            end_in_failure();
        end else begin
            repeat (8) @(posedge aclk);     // any late extra write fails in the monitor
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/core_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mycpu_top.sv
tb/tb_mycpu.sv
